/* bbox/bbox_extent.sv */
// ----------------------------------------------------------------------------
// Min/max extent of a triangle in x and y, combinational
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bbox_extent (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  raster_pkg::triangle_t  tri_in,
    output bbox_pkg::box_t         box
);

    import raster_pkg::*;

    // Smallest of three, earlier operand wins a tie
    function automatic coord_t min3(coord_t p, coord_t q, coord_t r);
        coord_t m;
        if ((p <= q) && (p <= r)) begin
            m = p;
        end else if (q <= r) begin
            m = q;
        end else begin
            m = r;
        end
        return m;
    endfunction

    // Largest of three, same tie rule
    function automatic coord_t max3(coord_t p, coord_t q, coord_t r);
        coord_t m;
        if ((p >= q) && (p >= r)) begin
            m = p;
        end else if (q >= r) begin
            m = q;
        end else begin
            m = r;
        end
        return m;
    endfunction

    // Signed compares, coord_t carries the sign
    always_comb begin
        box.ll_x = min3(tri_in.a.x, tri_in.b.x, tri_in.c.x);
        box.ll_y = min3(tri_in.a.y, tri_in.b.y, tri_in.c.y);
        box.ur_x = max3(tri_in.a.x, tri_in.b.x, tri_in.c.x);
        box.ur_y = max3(tri_in.a.y, tri_in.b.y, tri_in.c.y);
    end

    // Box must never be inverted on either axis
    a_box_ordered: assert property (
        @(posedge clk) disable iff (!rst_n)
        (box.ll_x <= box.ur_x) && (box.ll_y <= box.ur_y)
    ) else $error("bbox_extent: inverted box");

endmodule : bbox_extent

`default_nettype wire

/* bbox/bbox_snap_clip.sv */
// ----------------------------------------------------------------------------
// Floors a raw box to the MSAA sample grid, clamps it to the screen and
// rejects triangles whose box lies wholly off screen
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bbox_snap_clip (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  bbox_pkg::box_t          raw,
    input  wire logic               valid,
    input  bbox_pkg::raster_cfg_t   cfg,
    output bbox_pkg::box_t          clipped,
    output logic                    kept
);

    import raster_pkg::*;
    import bbox_pkg::*;

    // Fraction bits kept below the binary point, 0 to 3
    logic [1:0] keep_bits;

    // Mask on the fraction field only
    logic [frac_bits-1:0] frac_mask;

    // Whole-word mask, integer bits always pass
    coord_t floor_mask;

    // One sample edge in LSB units
    coord_t step;

    box_t floored;
    logic off_screen;

    // MSAA code to number of fraction bits that survive
    always_comb begin
        case (cfg.msaa)
            msaa_4x:  keep_bits = 2'd1;
            msaa_16x: keep_bits = 2'd2;
            msaa_64x: keep_bits = 2'd3;
            // 1x and every illegal code
            default:  keep_bits = 2'd0;
        endcase
    end

    assign frac_mask  = ~({frac_bits{1'b1}} >> keep_bits);
    assign floor_mask = {{(coord_bits - frac_bits){1'b1}}, frac_mask};
    assign step       = coord_t'(1) << (frac_bits - keep_bits);

    // Clearing low bits floors toward minus infinity, negatives too
    always_comb begin
        floored.ll_x = raw.ll_x & floor_mask;
        floored.ll_y = raw.ll_y & floor_mask;
        floored.ur_x = raw.ur_x & floor_mask;
        floored.ur_y = raw.ur_y & floor_mask;
    end

    // Clamp LL at the origin and UR at the screen edge
    always_comb begin
        clipped = floored;
        if (floored.ll_x < 0) begin
            clipped.ll_x = '0;
        end
        if (floored.ll_y < 0) begin
            clipped.ll_y = '0;
        end
        if (floored.ur_x >= cfg.screen_w) begin
            clipped.ur_x = cfg.screen_w;
        end
        if (floored.ur_y >= cfg.screen_h) begin
            clipped.ur_y = cfg.screen_h;
        end
    end

    // Reject test uses the floored box, before clamping
    assign off_screen = (floored.ur_x < 0) || (floored.ur_y < 0) ||
                        (floored.ll_x >= cfg.screen_w) ||
                        (floored.ll_y >= cfg.screen_h);

    assign kept = valid && !off_screen;

    // Floor moves a corner down by less than one sample
    property p_floor_err(r, f);
        @(posedge clk) disable iff (!rst_n)
        (f <= r) && ((r - f) < step);
    endproperty

    a_floor_ll_x: assert property (p_floor_err(raw.ll_x, floored.ll_x));
    a_floor_ll_y: assert property (p_floor_err(raw.ll_y, floored.ll_y));
    a_floor_ur_x: assert property (p_floor_err(raw.ur_x, floored.ur_x));
    a_floor_ur_y: assert property (p_floor_err(raw.ur_y, floored.ur_y));

    // A kept box is ordered and inside the screen
    a_kept_on_screen: assert property (
        @(posedge clk) disable iff (!rst_n)
        kept |-> (clipped.ll_x <= clipped.ur_x) && (clipped.ll_y <= clipped.ur_y) &&
                 (clipped.ur_x <= cfg.screen_w) && (clipped.ur_y <= cfg.screen_h)
    ) else $error("bbox_snap_clip: kept box outside screen");

endmodule : bbox_snap_clip

`default_nettype wire

/* bbox/bbox_unit.sv */
// ----------------------------------------------------------------------------
// Bounding-box stage top: extent, snap/clip and three pipeline registers
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bbox_unit (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  raster_pkg::tri_bundle_t  tri_in,
    input  wire logic                in_valid,
    // Shared stall, whole pipe holds while high
    input  wire logic                halt,
    input  bbox_pkg::raster_cfg_t    cfg,
    output raster_pkg::tri_bundle_t  tri_out,
    output bbox_pkg::box_t           box_out,
    output logic                     out_valid
);

    import bbox_pkg::*;

    // Stage 1 input, box straight from the vertices
    box_t          raw_box;
    extent_stage_t s1_d;

    // Stage 1 output
    extent_stage_t s1_q;
    logic          s1_valid;

    // Snapped box and on-screen flag
    box_t          clip_box;
    logic          clip_kept;
    bbox_stage_t   s2_d;

    // Stages 2 and 3
    bbox_stage_t   s2_q;
    logic          s2_valid;
    bbox_stage_t   s3_q;
    logic          s3_valid;

    bbox_extent u_extent (
        .clk    (clk),
        .rst_n  (rst_n),
        .tri_in (tri_in.geometry),
        .box    (raw_box)
    );

    assign s1_d = '{bundle: tri_in, box: raw_box};

    stage_reg #(.payload_t(extent_stage_t)) u_stage1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .halt    (halt),
        .d       (s1_d),
        .d_valid (in_valid),
        .q       (s1_q),
        .q_valid (s1_valid)
    );

    bbox_snap_clip u_snap_clip (
        .clk     (clk),
        .rst_n   (rst_n),
        .raw     (s1_q.box),
        .valid   (s1_valid),
        .cfg     (cfg),
        .clipped (clip_box),
        .kept    (clip_kept)
    );

    // Triangle and colour ride next to the clipped box
    assign s2_d = '{bundle: s1_q.bundle, box: clip_box};

    stage_reg #(.payload_t(bbox_stage_t)) u_stage2 (
        .clk     (clk),
        .rst_n   (rst_n),
        .halt    (halt),
        .d       (s2_d),
        .d_valid (clip_kept),
        .q       (s2_q),
        .q_valid (s2_valid)
    );

    stage_reg #(.payload_t(bbox_stage_t)) u_stage3 (
        .clk     (clk),
        .rst_n   (rst_n),
        .halt    (halt),
        .d       (s2_q),
        .d_valid (s2_valid),
        .q       (s3_q),
        .q_valid (s3_valid)
    );

    assign tri_out   = s3_q.bundle;
    assign box_out   = s3_q.box;
    assign out_valid = s3_valid;

endmodule : bbox_unit

`default_nettype wire

/* bbox_unit.f */
+incdir+bench
common/raster_pkg.sv
common/bbox_pkg.sv
bbox/bbox_extent.sv
bbox/bbox_snap_clip.sv
rtl/stage_reg.sv
bbox/bbox_unit.sv
bench/bbox_unit_tb.sv

/* bench/bbox_checks.svh */
// --------------------------------------------------------------------------
// Reference model of extent, floor, clamp and keep, plus typed compare tasks
// --------------------------------------------------------------------------
`ifndef BBOX_CHECKS_SVH
`define BBOX_CHECKS_SVH

// Expected contents of one pipe slot
typedef struct packed {
    tri_bundle_t bundle;
    box_t        box;
    logic        valid;
} expect_t;

// Sample edge in LSB units, unknown codes fall back to 1x
function automatic int sample_size(msaa_t m);
    case (m)
        msaa_4x:  return 512;
        msaa_16x: return 256;
        msaa_64x: return 128;
        default:  return 1024;
    endcase
endfunction

// Largest grid point not above v, works for negative values too
function automatic coord_t floor_to_grid(coord_t v, int size);
    int r;
    r = int'(v) % size;
    if (r < 0) begin
        r = r + size;
    end
    return coord_t'(int'(v) - r);
endfunction

// Min and max of x and y over the three vertices
function automatic box_t model_extent(triangle_t t);
    vertex_t v[3];
    box_t    b;
    v[0] = t.a;
    v[1] = t.b;
    v[2] = t.c;
    b = '{ll_x: v[0].x, ll_y: v[0].y, ur_x: v[0].x, ur_y: v[0].y};
    for (int i = 1; i < 3; i++) begin
        if (v[i].x < b.ll_x) begin
            b.ll_x = v[i].x;
        end
        if (v[i].y < b.ll_y) begin
            b.ll_y = v[i].y;
        end
        if (v[i].x > b.ur_x) begin
            b.ur_x = v[i].x;
        end
        if (v[i].y > b.ur_y) begin
            b.ur_y = v[i].y;
        end
    end
    return b;
endfunction

function automatic box_t floor_box(box_t raw, msaa_t m);
    box_t f;
    int   s;
    s = sample_size(m);
    f.ll_x = floor_to_grid(raw.ll_x, s);
    f.ll_y = floor_to_grid(raw.ll_y, s);
    f.ur_x = floor_to_grid(raw.ur_x, s);
    f.ur_y = floor_to_grid(raw.ur_y, s);
    return f;
endfunction

// LL stops at the origin, UR at the screen size
function automatic box_t clamp_box(box_t f, raster_cfg_t c);
    box_t b;
    b = f;
    if (f.ll_x < 0) begin
        b.ll_x = '0;
    end
    if (f.ll_y < 0) begin
        b.ll_y = '0;
    end
    if (f.ur_x >= c.screen_w) begin
        b.ur_x = c.screen_w;
    end
    if (f.ur_y >= c.screen_h) begin
        b.ur_y = c.screen_h;
    end
    return b;
endfunction

// Takes the floored box, before any clamping
function automatic logic model_keep(box_t f, logic v, raster_cfg_t c);
    logic off;
    off = (f.ur_x < 0) || (f.ur_y < 0) || (f.ll_x >= c.screen_w) || (f.ll_y >= c.screen_h);
    return v && !off;
endfunction

function automatic expect_t predict(tri_bundle_t b, logic v, raster_cfg_t c);
    expect_t e;
    box_t    fl;
    fl = floor_box(model_extent(b.geometry), c.msaa);
    e.bundle = b;
    e.box    = clamp_box(fl, c);
    e.valid  = model_keep(fl, v, c);
    return e;
endfunction

task automatic check_box(input box_t act, input box_t exp, input string name);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
endtask

task automatic check_bundle(input tri_bundle_t act, input tri_bundle_t exp, input string name);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
    end
endtask

task automatic check_valid(input logic act, input logic exp, input string name);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
    end
endtask

`endif

/* bench/bbox_unit_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the bbox unit with clock, reset, scoreboard and directed tests
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bbox_unit_tb;

    import raster_pkg::*;
    import bbox_pkg::*;

    localparam int drive_delay = 2;
    // Tests take roughly 350 cycles
    localparam int timeout_cycles = 1500;
    // Longest wait for a single result
    localparam int wait_limit = 40;

    logic        clk;
    logic        rst_n;
    tri_bundle_t tri_in;
    logic        in_valid;
    logic        halt;
    raster_cfg_t cfg;
    tri_bundle_t tri_out;
    box_t        box_out;
    logic        out_valid;

    int     errors;
    int     checks;
    int     delivered;
    integer seed;

    `include "bbox_checks.svh"

    // Model of the three pipe slots with the output stage at index 0
    expect_t     pipe_q[$];
    logic        last_adv;
    logic        last_halt;
    tri_bundle_t prev_tri;
    box_t        prev_box;
    logic        prev_valid;

    bbox_unit u_bbox_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .tri_in    (tri_in),
        .in_valid  (in_valid),
        .halt      (halt),
        .cfg       (cfg),
        .tri_out   (tri_out),
        .box_out   (box_out),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // Push what the DUT accepts while inputs are stable at the edge
    always @(posedge clk) begin
        if (!rst_n) begin
            pipe_q.delete();
            last_adv  = 1'b0;
            last_halt = 1'b0;
        end else if (!halt) begin
            pipe_q.push_back(predict(tri_in, in_valid, cfg));
            if (pipe_q.size() > bbox_latency) begin
                void'(pipe_q.pop_front());
            end
            last_adv  = 1'b1;
            last_halt = 1'b0;
        end else begin
            last_adv  = 1'b0;
            last_halt = 1'b1;
        end
    end

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (last_halt) begin
                check_bundle(tri_out, prev_tri, "tri_out held");
                check_box(box_out, prev_box, "box_out held");
                check_valid(out_valid, prev_valid, "out_valid held");
            end
            if (pipe_q.size() == bbox_latency) begin
                check_valid(out_valid, pipe_q[0].valid, "out_valid");
                if (pipe_q[0].valid) begin
                    check_bundle(tri_out, pipe_q[0].bundle, "tri_out");
                    check_box(box_out, pipe_q[0].box, "box_out");
                end
            end else begin
                check_valid(out_valid, 1'b0, "out_valid");
            end
            if (last_adv && out_valid) begin
                delivered++;
            end
        end
        prev_tri   = tri_out;
        prev_box   = box_out;
        prev_valid = out_valid;
    end

    // Real value to 10-bit-fraction fixed point
    function automatic coord_t fix(real v);
        return coord_t'($rtoi(v * 1024.0));
    endfunction

    function automatic tri_bundle_t make_bundle(real ax, real ay, real bx, real by,
                                                real cx, real cy);
        tri_bundle_t b;
        b.geometry.a = '{x: fix(ax), y: fix(ay), z: fix(0.5)};
        b.geometry.b = '{x: fix(bx), y: fix(by), z: fix(1.25)};
        b.geometry.c = '{x: fix(cx), y: fix(cy), z: fix(2.0)};
        b.color      = '{r: 24'h12_3456, g: 24'h00_ffff, b: 24'h80_0001};
        return b;
    endfunction

    function automatic coord_t coord_between(int lo, int span);
        int r;
        r = $unsigned($random(seed)) % (span * 1024);
        return coord_t'(lo * 1024 + r);
    endfunction

    function automatic tri_bundle_t random_bundle();
        tri_bundle_t b;
        b.geometry.a = '{x: coord_between(-64, 768), y: coord_between(-64, 608),
                         z: coord_between(0, 64)};
        b.geometry.b = '{x: coord_between(-64, 768), y: coord_between(-64, 608),
                         z: coord_between(0, 64)};
        b.geometry.c = '{x: coord_between(-64, 768), y: coord_between(-64, 608),
                         z: coord_between(0, 64)};
        b.color      = '{r: chan_t'($random(seed)), g: chan_t'($random(seed)),
                         b: chan_t'($random(seed))};
        return b;
    endfunction

    task automatic step();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic apply_reset();
        rst_n    = 1'b0;
        halt     = 1'b0;
        in_valid = 1'b0;
        tri_in   = '0;
        repeat (4) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
    endtask

    // One item that the next edge accepts
    task automatic send(input tri_bundle_t b, input logic v);
        tri_in   = b;
        in_valid = v;
        step();
        in_valid = 1'b0;
    endtask

    // Counts edges since send including the one send used
    task automatic wait_result(output int edges);
        edges = 1;
        while (!out_valid && edges < wait_limit) begin
            step();
            edges++;
        end
        if (!out_valid) begin
            errors++;
            $display("No result came out within %0d cycles", wait_limit);
        end
    endtask

    // Bubbles until no valid item is left in the pipe
    task automatic drain();
        in_valid = 1'b0;
        repeat (bbox_latency) step();
    endtask

    task automatic expect_dropped(input tri_bundle_t b, input logic v, input string name);
        send(b, v);
        repeat (bbox_latency - 1) step();
        check_valid(out_valid, 1'b0, {"out_valid ", name});
    endtask

    // Halt for a random stretch of 1 to 4 edges or not at all
    task automatic hold_random(inout int edges, inout int halted);
        int len;
        if (($unsigned($random(seed)) % 3) == 0) begin
            len  = 1 + $unsigned($random(seed)) % 4;
            halt = 1'b1;
            repeat (len) begin
                step();
                edges++;
                halted++;
            end
            halt = 1'b0;
        end
    endtask

    task automatic reset_and_latency();
        tri_bundle_t b;
        box_t        exp;
        int          edges;
        cfg.msaa = msaa_1x;
        check_valid(out_valid, 1'b0, "out_valid after reset");
        b = make_bundle(10.25, 20.5, 30.75, 5.125, 15.0, 40.875);
        send(b, 1'b1);
        wait_result(edges);
        checks++;
        if (edges != bbox_latency) begin
            errors++;
            $display("Result took %0d cycles instead of %0d", edges, bbox_latency);
        end
        exp = '{ll_x: fix(10.0), ll_y: fix(5.0), ur_x: fix(30.0), ur_y: fix(40.0)};
        check_box(box_out, exp, "box_out");
        check_bundle(tri_out, b, "tri_out");
        drain();
    endtask

    task automatic sample_grid_codes();
        msaa_t       codes[5];
        tri_bundle_t b;
        box_t        ext;
        int          edges;
        codes = '{msaa_1x, msaa_4x, msaa_16x, msaa_64x, msaa_t'(4'b0110)};
        b     = make_bundle(3.6875, 7.9375, 12.3125, 2.5625, 8.8125, 11.1875);
        ext   = model_extent(b.geometry);
        foreach (codes[i]) begin
            cfg.msaa = codes[i];
            send(b, 1'b1);
            wait_result(edges);
            check_box(box_out, clamp_box(floor_box(ext, codes[i]), cfg), "box_out grid");
            // Illegal code must floor like 1x
            if (i == 4) begin
                check_box(box_out, clamp_box(floor_box(ext, msaa_1x), cfg), "box_out bad msaa");
            end
            drain();
        end
    endtask

    task automatic clamp_and_reject();
        tri_bundle_t b;
        box_t        exp;
        int          edges;
        cfg.msaa = msaa_1x;
        b = make_bundle(-5.5, -3.25, 20.5, 2.0, 3.0, 15.75);
        send(b, 1'b1);
        wait_result(edges);
        exp = '{ll_x: '0, ll_y: '0, ur_x: fix(20.0), ur_y: fix(15.0)};
        check_box(box_out, exp, "box_out origin clamp");
        drain();
        b = make_bundle(600.5, 470.25, 700.75, 300.0, 630.0, 520.5);
        send(b, 1'b1);
        wait_result(edges);
        exp = '{ll_x: fix(600.0), ll_y: fix(300.0), ur_x: cfg.screen_w, ur_y: cfg.screen_h};
        check_box(box_out, exp, "box_out far clamp");
        drain();
        expect_dropped(make_bundle(-50.5, 10.0, -0.25, 20.0, -30.0, 40.0), 1'b1, "left");
        expect_dropped(make_bundle(10.0, -40.0, 50.0, -0.5, 30.0, -20.0), 1'b1, "below");
        expect_dropped(make_bundle(640.0, 10.0, 700.0, 50.0, 655.5, 30.0), 1'b1, "right");
        expect_dropped(make_bundle(10.0, 480.0, 50.0, 520.0, 30.0, 600.0), 1'b1, "above");
        expect_dropped(make_bundle(10.0, 10.0, 50.0, 50.0, 30.0, 30.0), 1'b0, "bubble");
    endtask

    task automatic halt_stream();
        tri_bundle_t b;
        int          n_tri;
        int          edges;
        int          halted;
        int          last_at;
        int          halted_at;
        n_tri    = 12;
        cfg.msaa = msaa_16x;
        edges    = 0;
        halted   = 0;
        last_at  = 0;
        delivered = 0;
        for (int i = 0; i < n_tri; i++) begin
            b        = make_bundle(1.0 + i, 2.0 + i, 30.5 + i, 5.25 + i, 12.75 + i, 40.0 + i);
            tri_in   = b;
            in_valid = 1'b1;
            hold_random(edges, halted);
            step();
            edges++;
        end
        in_valid = 1'b0;
        while (delivered < n_tri && edges < wait_limit * n_tri) begin
            hold_random(edges, halted);
            step();
            edges++;
            if (last_at == 0 && out_valid && tri_out === b) begin
                last_at   = edges;
                halted_at = halted;
            end
        end
        drain();
        checks += 2;
        if (delivered != n_tri) begin
            errors++;
            $display("%0d results came out for %0d triangles", delivered, n_tri);
        end
        // Last item needs its accept edge and two more plus one per halt
        if (last_at != n_tri + bbox_latency - 1 + halted_at) begin
            errors++;
            $display("Last triangle seen at edge %0d, wrong for %0d halted edges",
                     last_at, halted_at);
        end
    endtask

    task automatic sweep_random();
        int         sel;
        logic [3:0] code;
        for (int i = 0; i < 200; i++) begin
            // New MSAA code only with the pipe empty
            if (i % 25 == 0) begin
                drain();
                sel      = $unsigned($random(seed)) % 5;
                code     = (sel < 4) ? (4'b1000 >> sel) : 4'($random(seed));
                cfg.msaa = msaa_t'(code);
            end
            send(random_bundle(), ($random(seed) & 7) != 0);
        end
        drain();
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        delivered = 0;
        seed      = 32'h14b3_162a;
        last_adv  = 1'b0;
        last_halt = 1'b0;
        cfg       = '{screen_w: fix(640.0), screen_h: fix(480.0), msaa: msaa_1x};
        apply_reset();
        reset_and_latency();
        sample_grid_codes();
        clamp_and_reject();
        halt_stream();
        sweep_random();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : bbox_unit_tb

`default_nettype wire

/* common/bbox_pkg.sv */
// ----------------------------------------------------------------------------
// Bounding-box types: box corners, MSAA codes, raster config, stage payloads
// ----------------------------------------------------------------------------
`default_nettype none

package bbox_pkg;

    // Register stages from triangle in to box out
    localparam int bbox_latency = 3;

    // Lower left and upper right corners, same format as vertices
    typedef struct packed {
        raster_pkg::coord_t ll_x;
        raster_pkg::coord_t ll_y;
        raster_pkg::coord_t ur_x;
        raster_pkg::coord_t ur_y;
    } box_t;

    // One-hot sample setting, other codes fall back to 1x
    typedef enum logic [3:0] {
        msaa_1x  = 4'b1000,
        msaa_4x  = 4'b0100,
        msaa_16x = 4'b0010,
        msaa_64x = 4'b0001
    } msaa_t;

    // Held stable while triangles are in flight
    typedef struct packed {
        raster_pkg::coord_t screen_w;
        raster_pkg::coord_t screen_h;
        msaa_t              msaa;
    } raster_cfg_t;

    // After stage 1: raw min/max box
    typedef struct packed {
        raster_pkg::tri_bundle_t bundle;
        box_t                    box;
    } extent_stage_t;

    // Stages 2 and 3: box already floored and clamped
    typedef struct packed {
        raster_pkg::tri_bundle_t bundle;
        box_t                    box;
    } bbox_stage_t;

endpackage : bbox_pkg

`default_nettype wire

/* common/raster_pkg.sv */
// ----------------------------------------------------------------------------
// Fixed-point format and geometry types for the raster front end:
// coordinates, vertices, triangles, colour and the triangle bundle
// ----------------------------------------------------------------------------
`default_nettype none

package raster_pkg;

    // Width of every coordinate and colour value
    localparam int coord_bits = 24;

    // Fraction bits, integer part sits above them
    localparam int frac_bits = 10;

    // Signed position, two's complement fixed point
    typedef logic signed [coord_bits-1:0] coord_t;

    // Colour channel is never negative
    typedef logic [coord_bits-1:0] chan_t;

    // One vertex in screen space
    typedef struct packed {
        coord_t x;
        coord_t y;
        // Depth only rides along here
        coord_t z;
    } vertex_t;

    // Three vertices, a is the first one on tie breaks
    typedef struct packed {
        vertex_t a;
        vertex_t b;
        vertex_t c;
    } triangle_t;

    // Flat colour for the whole triangle
    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } color_t;

    // Everything that goes through the bbox pipe untouched
    typedef struct packed {
        triangle_t geometry;
        color_t    color;
    } tri_bundle_t;

endpackage : raster_pkg

`default_nettype wire

/* rtl/stage_reg.sv */
// ----------------------------------------------------------------------------
// Pipeline register for any payload type, with valid bit and halt hold
// ----------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic  clk,
    input  wire logic  rst_n,
    // High freezes the stage
    input  wire logic  halt,
    input  payload_t   d,
    input  wire logic  d_valid,
    output payload_t   q,
    output logic       q_valid
);

    // Bubbles load like data, halt holds both
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q       <= '0;
            q_valid <= 1'b0;
        end else if (!halt) begin
            q       <= d;
            q_valid <= d_valid;
        end
    end

    // Valid must stay known through any halt pattern
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(q_valid)
    ) else $error("stage_reg: q_valid unknown");

endmodule : stage_reg

`default_nettype wire
